//--- Bender.yml
package:
  name: rv_execute_unit

sources:
  - files:
      - hdl/rvExecPkg.sv
      - hdl/aluIssueIf.sv
      - hdl/instrDecoder.sv
      - hdl/registerFile.sv
      - hdl/alu.sv
      - hdl/rvExecuteUnit.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/rvExecuteUnitTb.sv

//--- hdl/alu.sv
`timescale 1ns/1ps

module alu (
	input  logic clk,
	input  logic reset,
	aluIssueIf.alu issue,
	output logic wrEn,
	output logic [rvExecPkg::REG_ADDR_W-1:0] wrAddr,
	output logic [rvExecPkg::XLEN-1:0] wrData
);

	localparam int XLEN = rvExecPkg::XLEN;

	logic [XLEN-1:0] a;
	logic [XLEN-1:0] b;
	logic signed [XLEN-1:0] aS;
	logic signed [XLEN-1:0] bS;
	logic [5:0] shamt;
	logic signed [2*XLEN-1:0] prodSS;
	logic signed [2*XLEN-1:0] prodSU;
	logic [2*XLEN-1:0] prodUU;
	logic divByZero;
	logic divOverflow;
	logic [XLEN-1:0] result;

	assign a = issue.operandA;
	assign b = issue.operandB;
	assign aS = $signed(issue.operandA);
	assign bS = $signed(issue.operandB);
	assign shamt = issue.operandB[5:0];

	// Full 128-bit products, the high multiplies take the upper half
	assign prodSS = aS * bS;
	assign prodSU = $signed({a[XLEN-1], a}) * $signed({1'b0, b});
	assign prodUU = a * b;

	// RISC-V division corner cases
	assign divByZero = (b == '0);
	assign divOverflow = (a == {1'b1, {(XLEN-1){1'b0}}}) && (b == '1);

	always_comb begin
		case (issue.op)
			rvExecPkg::ADD:  result = a + b;
			rvExecPkg::SUB:  result = a - b;
			rvExecPkg::SLL:  result = a << shamt;
			rvExecPkg::SLT:  result = {{(XLEN-1){1'b0}}, aS < bS};
			rvExecPkg::SLTU: result = {{(XLEN-1){1'b0}}, a < b};
			rvExecPkg::XOR:  result = a ^ b;
			rvExecPkg::SRL:  result = a >> shamt;
			rvExecPkg::SRA:  result = aS >>> shamt;
			rvExecPkg::OR:   result = a | b;
			rvExecPkg::AND:  result = a & b;
			rvExecPkg::MUL:    result = prodUU[XLEN-1:0]; // Low half is sign agnostic
			rvExecPkg::MULH:   result = prodSS[2*XLEN-1:XLEN];
			rvExecPkg::MULHSU: result = prodSU[2*XLEN-1:XLEN];
			rvExecPkg::MULHU:  result = prodUU[2*XLEN-1:XLEN];
			rvExecPkg::DIV: begin
				if (divByZero)
					result = '1;
				else if (divOverflow)
					result = a; // Most negative / -1 wraps to itself
				else
					result = aS / bS;
			end
			rvExecPkg::DIVU: begin
				if (divByZero)
					result = '1;
				else
					result = a / b;
			end
			rvExecPkg::REM: begin
				if (divByZero)
					result = a;
				else if (divOverflow)
					result = '0;
				else
					result = aS % bS; // Sign follows the dividend
			end
			rvExecPkg::REMU: begin
				if (divByZero)
					result = a;
				else
					result = a % b;
			end
			default: result = '0;
		endcase
	end

	// Writeback stage
	always_ff @(posedge clk) begin
		if (reset)
			wrEn <= 1'b0;
		else
			wrEn <= issue.valid;
		wrAddr <= issue.rd;
		wrData <= result;
	end

	// Decoder only produces enumerated operations
	assert property (@(posedge clk) disable iff (reset)
		issue.valid |-> (issue.op <= rvExecPkg::REMU));

endmodule

//--- hdl/aluIssueIf.sv
`timescale 1ns/1ps

// Decoded operation handed from the decoder stage to the ALU stage
interface aluIssueIf;

	logic valid; // One cycle per issued instruction
	rvExecPkg::aluOpT op;
	logic [rvExecPkg::XLEN-1:0] operandA;
	logic [rvExecPkg::XLEN-1:0] operandB; // Register, immediate or shamt
	logic [rvExecPkg::REG_ADDR_W-1:0] rd;

	modport decoder (
		output valid,
		output op,
		output operandA,
		output operandB,
		output rd
	);

	modport alu (
		input valid,
		input op,
		input operandA,
		input operandB,
		input rd
	);

endinterface

//--- hdl/instrDecoder.sv
`timescale 1ns/1ps

module instrDecoder (
	input  logic clk,
	input  logic reset,
	input  logic instrValid,
	input  logic [rvExecPkg::ILEN-1:0] instr,
	output logic [rvExecPkg::REG_ADDR_W-1:0] rs1Addr,
	output logic [rvExecPkg::REG_ADDR_W-1:0] rs2Addr,
	input  logic [rvExecPkg::XLEN-1:0] rs1Data,
	input  logic [rvExecPkg::XLEN-1:0] rs2Data,
	output logic illegal,
	aluIssueIf.decoder issue
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic [5:0] funct6;
	logic [rvExecPkg::XLEN-1:0] immSext;
	logic [rvExecPkg::XLEN-1:0] shamtZext;
	rvExecPkg::aluOpT decOp;
	logic [rvExecPkg::XLEN-1:0] decB;
	logic decIllegal;

	assign opcode = instr[6:0];
	assign funct3 = instr[14:12];
	assign funct7 = instr[31:25];
	assign funct6 = instr[31:26];

	// Register file is read in the strobe cycle, before the edge
	assign rs1Addr = instr[19:15];
	assign rs2Addr = instr[24:20];

	assign immSext = {{(rvExecPkg::XLEN-12){instr[31]}}, instr[31:20]};
	assign shamtZext = {{(rvExecPkg::XLEN-6){1'b0}}, instr[25:20]};

	always_comb begin
		decOp = rvExecPkg::ADD;
		decB = rs2Data;
		decIllegal = 1'b0;
		case (opcode)
			rvExecPkg::OPC_OP: begin
				if (funct7 == rvExecPkg::FUNCT7_BASE) begin
					case (funct3)
						rvExecPkg::F3_ADD_SUB: decOp = rvExecPkg::ADD;
						rvExecPkg::F3_SLL:     decOp = rvExecPkg::SLL;
						rvExecPkg::F3_SLT:     decOp = rvExecPkg::SLT;
						rvExecPkg::F3_SLTU:    decOp = rvExecPkg::SLTU;
						rvExecPkg::F3_XOR:     decOp = rvExecPkg::XOR;
						rvExecPkg::F3_SR:      decOp = rvExecPkg::SRL;
						rvExecPkg::F3_OR:      decOp = rvExecPkg::OR;
						default:               decOp = rvExecPkg::AND;
					endcase
				end else if (funct7 == rvExecPkg::FUNCT7_ALT) begin
					if (funct3 == rvExecPkg::F3_ADD_SUB)
						decOp = rvExecPkg::SUB;
					else if (funct3 == rvExecPkg::F3_SR)
						decOp = rvExecPkg::SRA;
					else
						decIllegal = 1'b1; // Only SUB and SRA use the alternate funct7
				end else if (funct7 == rvExecPkg::FUNCT7_MULDIV) begin
					case (funct3) // M extension order follows funct3
						3'b000:  decOp = rvExecPkg::MUL;
						3'b001:  decOp = rvExecPkg::MULH;
						3'b010:  decOp = rvExecPkg::MULHSU;
						3'b011:  decOp = rvExecPkg::MULHU;
						3'b100:  decOp = rvExecPkg::DIV;
						3'b101:  decOp = rvExecPkg::DIVU;
						3'b110:  decOp = rvExecPkg::REM;
						default: decOp = rvExecPkg::REMU;
					endcase
				end else begin
					decIllegal = 1'b1;
				end
			end
			rvExecPkg::OPC_OP_IMM: begin
				decB = immSext; // SLTIU compares this unsigned
				case (funct3)
					rvExecPkg::F3_ADD_SUB: decOp = rvExecPkg::ADD;
					rvExecPkg::F3_SLT:     decOp = rvExecPkg::SLT;
					rvExecPkg::F3_SLTU:    decOp = rvExecPkg::SLTU;
					rvExecPkg::F3_XOR:     decOp = rvExecPkg::XOR;
					rvExecPkg::F3_OR:      decOp = rvExecPkg::OR;
					rvExecPkg::F3_AND:     decOp = rvExecPkg::AND;
					rvExecPkg::F3_SLL: begin
						decOp = rvExecPkg::SLL;
						decB = shamtZext;
						decIllegal = (funct6 != rvExecPkg::FUNCT6_SRL);
					end
					default: begin
						decB = shamtZext;
						if (funct6 == rvExecPkg::FUNCT6_SRA)
							decOp = rvExecPkg::SRA;
						else
							decOp = rvExecPkg::SRL;
						decIllegal = (funct6 != rvExecPkg::FUNCT6_SRL) &&
							(funct6 != rvExecPkg::FUNCT6_SRA);
					end
				endcase
			end
			default: decIllegal = 1'b1;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			issue.valid <= 1'b0;
			illegal <= 1'b0;
		end else begin
			issue.valid <= instrValid && !decIllegal;
			illegal <= instrValid && decIllegal;
		end
		issue.op <= decOp;
		issue.operandA <= rs1Data;
		issue.operandB <= decB;
		issue.rd <= instr[11:7];
	end

	// A strobed word must be fully driven
	assert property (@(posedge clk) disable iff (reset) instrValid |-> !$isunknown(instr));

endmodule

//--- hdl/registerFile.sv
`timescale 1ns/1ps

module registerFile (
	input  logic clk,
	input  logic reset,
	input  logic [rvExecPkg::REG_ADDR_W-1:0] rs1Addr,
	input  logic [rvExecPkg::REG_ADDR_W-1:0] rs2Addr,
	input  logic wrEn,
	input  logic [rvExecPkg::REG_ADDR_W-1:0] wrAddr,
	input  logic [rvExecPkg::XLEN-1:0] wrData,
	output logic [rvExecPkg::XLEN-1:0] rs1Data,
	output logic [rvExecPkg::XLEN-1:0] rs2Data
);

	localparam int NUM_REGS = 1 << rvExecPkg::REG_ADDR_W;

	// x0 has no storage
	logic [rvExecPkg::XLEN-1:0] regs [1:NUM_REGS-1];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 1; i < NUM_REGS; i++)
				regs[i] <= '0;
		end else if (wrEn && wrAddr != '0) begin
			regs[wrAddr] <= wrData;
		end
	end

	// Reads see the array as it stood before the edge
	always_comb begin
		if (rs1Addr == '0)
			rs1Data = '0;
		else
			rs1Data = regs[rs1Addr];
	end

	always_comb begin
		if (rs2Addr == '0)
			rs2Data = '0;
		else
			rs2Data = regs[rs2Addr];
	end

	assert property (@(posedge clk) disable iff (reset) wrEn |-> !$isunknown(wrData));

endmodule

//--- hdl/rvExecPkg.sv
package rvExecPkg;

	// Datapath widths
	localparam int XLEN       = 64;
	localparam int ILEN       = 32;
	localparam int REG_ADDR_W = 5;

	// Major opcodes handled by this slice
	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

	// funct7 variants of the OP opcode
	localparam logic [6:0] FUNCT7_BASE   = 7'b0000000;
	localparam logic [6:0] FUNCT7_ALT    = 7'b0100000; // SUB and SRA
	localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001;

	// RV64 immediate shifts carry a 6-bit shamt, so only funct6 is left
	localparam logic [5:0] FUNCT6_SRL = 6'b000000;
	localparam logic [5:0] FUNCT6_SRA = 6'b010000;

	// Base integer funct3 encodings
	localparam logic [2:0] F3_ADD_SUB = 3'b000;
	localparam logic [2:0] F3_SLL     = 3'b001;
	localparam logic [2:0] F3_SLT     = 3'b010;
	localparam logic [2:0] F3_SLTU    = 3'b011;
	localparam logic [2:0] F3_XOR     = 3'b100;
	localparam logic [2:0] F3_SR      = 3'b101; // SRL or SRA by funct7
	localparam logic [2:0] F3_OR      = 3'b110;
	localparam logic [2:0] F3_AND     = 3'b111;

	// ALU operations, immediates are folded into operandB before issue
	typedef enum logic [4:0] {
		ADD,
		SUB,
		SLL,
		SLT,
		SLTU,
		XOR,
		SRL,
		SRA,
		OR,
		AND,
		MUL,
		MULH,
		MULHSU,
		MULHU,
		DIV,
		DIVU,
		REM,
		REMU
	} aluOpT;

endpackage

//--- hdl/rvExecuteUnit.sv
`timescale 1ns/1ps

module rvExecuteUnit (
	input  logic clk,
	input  logic reset,
	input  logic instrValid,
	input  logic [rvExecPkg::ILEN-1:0] instr,
	output logic wbValid,
	output logic [rvExecPkg::REG_ADDR_W-1:0] wbRd,
	output logic [rvExecPkg::XLEN-1:0] wbData,
	output logic illegal
);

	logic [rvExecPkg::REG_ADDR_W-1:0] rs1Addr;
	logic [rvExecPkg::REG_ADDR_W-1:0] rs2Addr;
	logic [rvExecPkg::XLEN-1:0] rs1Data;
	logic [rvExecPkg::XLEN-1:0] rs2Data;
	logic wrEn;
	logic [rvExecPkg::REG_ADDR_W-1:0] wrAddr;
	logic [rvExecPkg::XLEN-1:0] wrData;

	aluIssueIf issueBus ();

	instrDecoder decoder (
		.clk(clk),
		.reset(reset),
		.instrValid(instrValid),
		.instr(instr),
		.rs1Addr(rs1Addr),
		.rs2Addr(rs2Addr),
		.rs1Data(rs1Data),
		.rs2Data(rs2Data),
		.illegal(illegal),
		.issue(issueBus.decoder)
	);

	registerFile regFile (
		.clk(clk),
		.reset(reset),
		.rs1Addr(rs1Addr),
		.rs2Addr(rs2Addr),
		.wrEn(wrEn),
		.wrAddr(wrAddr),
		.wrData(wrData),
		.rs1Data(rs1Data),
		.rs2Data(rs2Data)
	);

	alu execAlu (
		.clk(clk),
		.reset(reset),
		.issue(issueBus.alu),
		.wrEn(wrEn),
		.wrAddr(wrAddr),
		.wrData(wrData)
	);

	// Writeback is reported in the same cycle the register file takes it
	assign wbValid = wrEn;
	assign wbRd = wrAddr;
	assign wbData = wrData;

endmodule

//--- rvExecuteUnit.f
+incdir+verification
hdl/rvExecPkg.sv
hdl/aluIssueIf.sv
hdl/instrDecoder.sv
hdl/registerFile.sv
hdl/alu.sv
hdl/rvExecuteUnit.sv
verification/rvExecuteUnitTb.sv

//--- verification/rvExecModel.svh
`ifndef RV_EXEC_MODEL_SVH
`define RV_EXEC_MODEL_SVH

// Architectural registers as the issuer expects them
logic [63:0] modelRegs [0:31];

// Instruction in the ALU stage, then expected outputs after each edge
logic issValid;
logic [4:0] issRd;
logic [63:0] issData;
logic expWbValid;
logic [4:0] expWbRd;
logic [63:0] expWbData;
logic expIllegal;

function automatic logic isIllegal(input logic [31:0] w);
	if (w[6:0] == 7'b0110011) begin
		if (w[31:25] == 7'b0100000)
			return !(w[14:12] == 3'b000 || w[14:12] == 3'b101); // SUB and SRA only
		return !(w[31:25] == 7'b0000000 || w[31:25] == 7'b0000001);
	end
	if (w[6:0] != 7'b0010011)
		return 1'b1;
	if (w[14:12] == 3'b001)
		return w[31:26] != 6'b000000;
	if (w[14:12] == 3'b101)
		return !(w[31:26] == 6'b000000 || w[31:26] == 6'b010000);
	return 1'b0;
endfunction

// Divide on magnitudes, so the most negative value by -1 wraps on its own
function automatic logic [63:0] signedDivRem(input logic [63:0] a, input logic [63:0] b,
		input bit rem);
	logic [63:0] magA;
	logic [63:0] magB;
	magA = a[63] ? -a : a;
	magB = b[63] ? -b : b;
	if (rem)
		return a[63] ? -(magA % magB) : magA % magB; // Remainder takes the dividend sign
	return (a[63] ^ b[63]) ? -(magA / magB) : magA / magB;
endfunction

function automatic logic [63:0] computeResult(input logic [31:0] w, input logic [63:0] a,
		input logic [63:0] r2);
	logic [63:0] b;
	logic [5:0] sh;
	logic [127:0] wide;
	logic [2:0] f3;
	logic alt;
	f3 = w[14:12];
	if (w[6:0] == 7'b0010011) begin
		b = {{52{w[31]}}, w[31:20]};
		sh = w[25:20];
		alt = (f3 == 3'b101) && w[30]; // SRAI
	end else begin
		b = r2;
		sh = r2[5:0];
		alt = w[30];
	end
	if (w[6:0] == 7'b0110011 && w[25]) begin
		case (f3)
			3'b000: return a * b;
			3'b001: wide = {{64{a[63]}}, a} * {{64{b[63]}}, b};
			3'b010: wide = {{64{a[63]}}, a} * {64'd0, b};
			3'b011: wide = {64'd0, a} * {64'd0, b};
			3'b100: return (b == 0) ? '1 : signedDivRem(a, b, 1'b0);
			3'b101: return (b == 0) ? '1 : a / b;
			3'b110: return (b == 0) ? a : signedDivRem(a, b, 1'b1);
			default: return (b == 0) ? a : a % b;
		endcase
		return wide[127:64];
	end
	case (f3)
		3'b000: return (alt && w[5]) ? a - b : a + b; // Only OP has SUB
		3'b001: return a << sh;
		3'b010: return {63'd0, $signed(a) < $signed(b)};
		3'b011: return {63'd0, a < b};
		3'b100: return a ^ b;
		3'b101: begin
			if (alt)
				return $signed(a) >>> sh;
			return a >> sh;
		end
		3'b110: return a | b;
		default: return a & b;
	endcase
endfunction

// One clock edge, operands read before the write due at this edge
task automatic modelStep(input logic rst, input logic valid, input logic [31:0] w);
	logic [63:0] rs1Val;
	logic [63:0] rs2Val;
	if (rst) begin
		for (int i = 0; i < 32; i++)
			modelRegs[i] = '0;
		issValid = 1'b0;
		expWbValid = 1'b0;
		expIllegal = 1'b0;
	end else begin
		rs1Val = modelRegs[w[19:15]];
		rs2Val = modelRegs[w[24:20]];
		if (expWbValid && expWbRd != 5'd0)
			modelRegs[expWbRd] = expWbData;
		expWbValid = issValid;
		expWbRd = issRd;
		expWbData = issData;
		issValid = valid && !isIllegal(w);
		issRd = w[11:7];
		issData = computeResult(w, rs1Val, rs2Val);
		expIllegal = valid && isIllegal(w);
	end
endtask

`endif

//--- verification/rvExecuteUnitTb.sv
`timescale 1ns/1ps

module rvExecuteUnitTb;

	localparam int CLK_PERIOD = 8;
	localparam int RESET_CYCLES = 16;
	localparam int NUM_BASE = 200;
	localparam int NUM_MULDIV = 200;
	localparam int NUM_CHAIN = 24;
	localparam int NUM_ILLEGAL = 40;
	localparam int NUM_BURST = 10;
	localparam int NUM_REWRITE = 20;
	// Four register sweeps, then idle gaps and corner setup
	localparam int NUM_INSTR = 4 * 32 + NUM_BASE + NUM_MULDIV + NUM_CHAIN + NUM_ILLEGAL
		+ NUM_BURST + NUM_REWRITE + 19;
	localparam int WATCHDOG_NS = (2 * RESET_CYCLES + NUM_INSTR + 20) * CLK_PERIOD;
	localparam logic [6:0] OPC_OP = 7'b0110011;
	localparam logic [6:0] OPC_IMM = 7'b0010011;

	logic clk = 1'b0;
	logic reset;
	logic instrValid;
	logic [31:0] instr;
	logic wbValid;
	logic [4:0] wbRd;
	logic [63:0] wbData;
	logic illegal;
	integer seed;
	int checkCount = 0;
	int errorCount = 0;

	`include "rvExecModel.svh"

	rvExecuteUnit u_dut (
		.clk(clk),
		.reset(reset),
		.instrValid(instrValid),
		.instr(instr),
		.wbValid(wbValid),
		.wbRd(wbRd),
		.wbData(wbData),
		.illegal(illegal)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	always @(posedge clk)
		modelStep(reset, instrValid, instr);

	task automatic checkValue(input string name, input logic [63:0] got,
			input logic [63:0] exp);
		checkCount++;
		if (got !== exp) begin
			errorCount++;
			$display("FAILED at %0d ns: %s = %h, expected %h", $time, name, got, exp);
		end
	endtask

	always @(negedge clk) begin // Outputs settled mid-cycle
		checkValue("wbValid", wbValid, expWbValid);
		checkValue("illegal", illegal, expIllegal);
		if (expWbValid) begin
			checkValue("wbRd", wbRd, expWbRd);
			checkValue("wbData", wbData, expWbData);
		end
	end

	task automatic issueInstr(input logic [31:0] w);
		@(posedge clk);
		instrValid <= 1'b1;
		instr <= w;
	endtask

	task automatic idleCycles(input int n);
		repeat (n) begin
			@(posedge clk);
			instrValid <= 1'b0;
		end
	endtask

	function automatic logic [31:0] iType(input logic [11:0] imm, input logic [2:0] f3,
			input logic [4:0] rd, input logic [4:0] rs1);
		return {imm, rs1, f3, rd, OPC_IMM};
	endfunction

	// OR x0, xN, x0 shows xN on wbData and leaves the registers alone
	task automatic readAllRegs();
		for (int i = 0; i < 32; i++)
			issueInstr({7'b0, 5'd0, 5'(i), 3'b110, 5'd0, OPC_OP});
	endtask

	function automatic logic [31:0] randBase();
		logic [31:0] r;
		logic [2:0] f3;
		r = $random(seed);
		f3 = r[2:0];
		if (r[3]) // Register form, alternate funct7 only on SUB and SRA
			return {1'b0, r[4] && (f3 == 3'b000 || f3 == 3'b101), 5'b0, r[19:15], r[14:10],
				f3, r[9:5], OPC_OP};
		if (f3[1:0] == 2'b01)
			return {1'b0, r[4] && f3[2], 4'b0, r[25:20], r[14:10], f3, r[9:5], OPC_IMM};
		return iType(r[31:20], f3, r[9:5], r[14:10]);
	endfunction

	function automatic logic [4:0] cornerReg();
		logic [31:0] r;
		r = $random(seed);
		if (r[0])
			return {3'b000, r[2:1]}; // x0..x3 hold 0, -1, most negative, 1
		return r[8:4];
	endfunction

	function automatic logic [31:0] randMulDiv();
		logic [31:0] r;
		logic [4:0] rd;
		r = $random(seed);
		rd = r[4:0];
		if (rd < 5'd4)
			rd = rd + 5'd4; // Corner registers stay intact
		return {7'b0000001, cornerReg(), cornerReg(), r[7:5], rd, OPC_OP};
	endfunction

	function automatic logic [31:0] randIllegal();
		logic [31:0] w;
		logic [1:0] kind;
		kind = 2'($random(seed));
		w = $random(seed);
		case (kind)
			2'd0: w[6] = 1'b1; // Neither OP nor OP-IMM has bit 6 set
			2'd1: w = {1'b1, w[30:7], OPC_OP};
			2'd2: w = {7'b0100000, w[24:15], w[14], 1'b1, w[12:7], OPC_OP};
			default: w = {1'b1, w[30:15], w[14], 2'b01, w[11:7], OPC_IMM}; // Bad funct6
		endcase
		return w;
	endfunction

	initial begin
		seed = 32'he7b6_46e0;
		reset = 1'b1;
		instrValid = 1'b0;
		instr = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b0;
		for (int i = 0; i < 32; i++)
			issueInstr(iType(12'($random(seed)), 3'b000, 5'(i), 5'd0)); // x0 too
		idleCycles(2);
		readAllRegs();
		for (int i = 0; i < NUM_BASE; i++)
			issueInstr(randBase());
		issueInstr(iType(12'hfff, 3'b000, 5'd1, 5'd0));
		issueInstr(iType(12'd1, 3'b000, 5'd2, 5'd0));
		issueInstr(iType(12'd1, 3'b000, 5'd3, 5'd0));
		idleCycles(2);
		issueInstr(iType(12'd63, 3'b001, 5'd2, 5'd2)); // x2 becomes the most negative value
		idleCycles(2);
		issueInstr({7'b0000001, 5'd1, 5'd2, 3'b100, 5'd7, OPC_OP}); // DIV and REM overflow
		issueInstr({7'b0000001, 5'd1, 5'd2, 3'b110, 5'd8, OPC_OP});
		for (int i = 0; i < NUM_MULDIV; i++)
			issueInstr(randMulDiv());
		for (int i = 0; i < NUM_CHAIN; i++) begin // Back-to-back on x5 and x6
			if (i % 2 == 0)
				issueInstr(iType(12'($random(seed)), 3'b000, 5'd5, 5'd5));
			else
				issueInstr({7'b0, 5'd6, 5'd5, 3'b000, 5'd6, OPC_OP});
		end
		for (int i = 0; i < NUM_ILLEGAL; i++)
			issueInstr(randIllegal());
		idleCycles(2);
		readAllRegs();
		for (int i = 0; i < NUM_BURST; i++)
			issueInstr(randBase());
		issueInstr(randIllegal()); // Reset lands on an illegal word with the burst in flight
		reset <= 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b0;
		instrValid <= 1'b0;
		readAllRegs();
		for (int i = 0; i < NUM_REWRITE; i++)
			issueInstr(randBase());
		idleCycles(4);
		$display("Checks: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired before the instruction sequence finished");
		$display("Test failed");
		$finish;
	end

endmodule
